/* modExpPkg.sv */
`default_nettype none

package modExpPkg;

	localparam int OpBits = 128;	// operand and result width
	localparam int WordBits = 64;	// load and readout word
	localparam int SliceBits = 32;	// adder slice
	localparam int WordsPerOp = OpBits / WordBits;
	localparam int SlicesPerOp = OpBits / SliceBits;
	localparam int SliceCntBits = $clog2(SlicesPerOp);
	localparam int NumOperands = 3;	// m, e and n load registers

	typedef logic [OpBits-1:0] operand_t;
	typedef logic [WordBits-1:0] word_t;
	typedef logic [SliceBits-1:0] slice_t;

	// operand set captured by the core at start
	typedef struct packed {
		operand_t m;
		operand_t e;
		operand_t n;
	} operandSet_t;

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} addSubOp_t;

	typedef struct packed {
		logic start;	// one-cycle pulse
		addSubOp_t op;	// sampled with start
		slice_t a;	// low slice of source a
		slice_t b;	// low slice of source b
	} addSubReq_t;

	typedef struct packed {
		logic shift;	// one strobe per slice
		slice_t sum;	// valid with shift
		logic done;	// with the last shift
	} addSubRsp_t;

	typedef enum logic [3:0] {
		idle,
		expBit,	// look at exponent low bit
		mulStep,	// look at multiplier low bit
		mulAdd,	// acc += tmp
		mulAddFix,	// acc -= n if needed
		mulDouble,	// tmp *= 2
		mulDoubleFix,	// tmp -= n if needed
		mulEnd,
		finish
	} coreState_t;

endpackage

`default_nettype wire

/* operandLoad.sv */
`timescale 1ns/100ps
`default_nettype none

module operandLoad import modExpPkg::*; (
	input  logic        iClk,
	input  logic        M_reset0,
	input  logic        wrM,
	input  logic        wrE,
	input  logic        wrN,
	input  word_t       m,
	input  word_t       e,
	input  word_t       n,
	output operandSet_t operands
);

	operand_t opReg [NumOperands];	// 0 is m, 1 is e, 2 is n
	word_t wordIn [NumOperands];
	logic [NumOperands-1:0] wr;

	assign wr = {wrN, wrE, wrM};
	assign wordIn[0] = m;
	assign wordIn[1] = e;
	assign wordIn[2] = n;

	// new word enters at the top, older words move down
	// so the first word written ends up least significant
	always_ff @(posedge iClk) begin
		for (int i = 0; i < NumOperands; i++) begin
			if (M_reset0) begin
				opReg[i] <= '0;
			end else if (wr[i]) begin
				opReg[i] <= {wordIn[i], opReg[i][OpBits-1:WordBits]};	// shift-right in
			end
		end
	end

	// held apart from the core copies, so loading may overlap a run
	assign operands = '{m: opReg[0], e: opReg[1], n: opReg[2]};

endmodule

`default_nettype wire

/* serialAddSub.sv */
`timescale 1ns/100ps
`default_nettype none

module serialAddSub import modExpPkg::*; (
	input  logic       iClk,
	input  logic       M_reset0,
	input  addSubReq_t req,
	output addSubRsp_t rsp
);

	logic active;	// slices are being processed
	logic [SliceCntBits-1:0] sliceCnt;
	addSubOp_t opReg;	// op held for the whole operand
	logic carry;	// carry or inverted borrow between slices
	slice_t bOp;
	logic [SliceBits:0] sumFull;
	logic lastSlice;

	// subtract as a + ~b + 1
	assign bOp = (opReg == opSub) ? ~req.b : req.b;
	assign sumFull = {1'b0, req.a} + {1'b0, bOp} + {{SliceBits{1'b0}}, carry};
	assign lastSlice = active && (sliceCnt == SliceCntBits'(SlicesPerOp - 1));

	assign rsp = '{shift: active, sum: sumFull[SliceBits-1:0], done: lastSlice};

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			active <= 1'b0;
			sliceCnt <= '0;
			opReg <= opAdd;
			carry <= 1'b0;
		end else if (req.start) begin
			active <= 1'b1;	// first shift next cycle
			sliceCnt <= '0;
			opReg <= req.op;
			carry <= (req.op == opSub);	// +1 of two's complement
		end else if (active) begin
			carry <= sumFull[SliceBits];	// into next slice
			sliceCnt <= sliceCnt + 1'b1;
			if (lastSlice) begin
				active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* modExpCore.sv */
`timescale 1ns/100ps
`default_nettype none

module modExpCore import modExpPkg::*; (
	input  logic        iClk,
	input  logic        M_reset0,
	input  logic        start,
	input  operandSet_t operands,
	output addSubReq_t  addSub,
	input  addSubRsp_t  addSubRsp,
	output operand_t    result,
	output logic        done
);

	coreState_t state;
	operand_t expCopy;	// shifts right per exponent step
	operand_t base;	// M^(2^k) mod n
	operand_t accR;	// running result R
	operand_t mulCopy;	// multiplier, shifts right per step
	operand_t tmp;	// multiplicand, doubles per step
	operand_t modN;	// captured n, rotates during subtracts
	logic pendSqr;	// multiply for this exponent bit is done
	logic toBase;	// product goes to base instead of R
	operand_t destVal;
	operand_t cmpVal;
	logic geN;
	logic fixDone;

	function automatic operand_t rotSlice(input operand_t v);
		return {v[SliceBits-1:0], v[OpBits-1:SliceBits]};
	endfunction

	function automatic operand_t shiftInSlice(input operand_t v, input slice_t s);
		return {s, v[OpBits-1:SliceBits]};
	endfunction

	assign destVal = toBase ? base : accR;	// product accumulator
	assign cmpVal = (state == mulDoubleFix) ? tmp : destVal;
	assign geN = (cmpVal >= modN);	// only used while modN is aligned
	// fix state leaves when the subtract ends or none is needed
	assign fixDone = addSubRsp.done || (!addSubRsp.shift && !geN);

	always_comb begin
		addSub.start = 1'b0;
		addSub.op = opSub;
		addSub.a = destVal[SliceBits-1:0];
		addSub.b = modN[SliceBits-1:0];
		case (state)
			mulStep: begin
				addSub.op = opAdd;
				addSub.b = tmp[SliceBits-1:0];
				addSub.start = mulCopy[0];	// acc += tmp
			end
			mulAdd: begin
				addSub.op = opAdd;
				addSub.b = tmp[SliceBits-1:0];
			end
			mulAddFix: addSub.start = !addSubRsp.shift && geN;	// acc -= n
			mulDoubleFix: begin
				addSub.a = tmp[SliceBits-1:0];
				addSub.start = !addSubRsp.shift && geN;	// tmp -= n
			end
			default: ;
		endcase
	end

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			state <= idle;
			pendSqr <= 1'b0;
			toBase <= 1'b0;
		end else begin
			case (state)
				idle: if (start) begin
					state <= expBit;
					pendSqr <= 1'b0;
				end
				expBit: if (expCopy[0] && !pendSqr) begin
					state <= mulStep;	// R = R * base
					pendSqr <= 1'b1;
					toBase <= 1'b0;
				end else if (expCopy[OpBits-1:1] == '0) begin
					state <= finish;	// no exponent bits left
				end else begin
					state <= mulStep;	// base = base * base
					pendSqr <= 1'b0;
					toBase <= 1'b1;
				end
				mulStep: if (mulCopy == '0) begin
					state <= mulEnd;	// early exit
				end else if (mulCopy[0]) begin
					state <= mulAdd;
				end else begin
					state <= mulDouble;
				end
				mulAdd: if (addSubRsp.done) state <= mulAddFix;
				mulAddFix: if (fixDone) state <= mulDouble;
				mulDouble: state <= mulDoubleFix;
				mulDoubleFix: if (fixDone) state <= mulStep;
				mulEnd: state <= expBit;
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// working registers
	always_ff @(posedge iClk) begin
		case (state)
			idle: if (start) begin
				expCopy <= operands.e;
				base <= operands.m;
				modN <= operands.n;
				accR <= OpBits'(1);
			end
			expBit: if (expCopy[0] && !pendSqr) begin
				tmp <= accR;
				mulCopy <= base;
				accR <= '0;	// product builds here
			end else if (expCopy[OpBits-1:1] != '0) begin
				tmp <= base;
				mulCopy <= base;
				base <= '0;	// square builds in base
				expCopy <= expCopy >> 1;
			end
			mulStep: mulCopy <= mulCopy >> 1;
			mulAdd, mulAddFix: if (addSubRsp.shift) begin
				if (toBase) begin
					base <= shiftInSlice(destVal, addSubRsp.sum);
				end else begin
					accR <= shiftInSlice(destVal, addSubRsp.sum);
				end
				if (state == mulAdd) begin
					tmp <= rotSlice(tmp);
				end else begin
					modN <= rotSlice(modN);
				end
			end
			mulDouble: tmp <= tmp << 1;	// tmp < n < 2^127, no overflow
			mulDoubleFix: if (addSubRsp.shift) begin
				tmp <= shiftInSlice(tmp, addSubRsp.sum);
				modN <= rotSlice(modN);
			end
			default: ;
		endcase
	end

	assign result = accR;
	assign done = (state == finish);	// one cycle, then idle

endmodule

`default_nettype wire

/* resultUnload.sv */
`timescale 1ns/100ps
`default_nettype none

module resultUnload import modExpPkg::*; (
	input  logic     iClk,
	input  logic     M_reset0,
	input  logic     capture,
	input  operand_t result,
	input  logic     rd,
	output word_t    out
);

	word_t [WordsPerOp-1:0] resBuf;	// word 0 is read first

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			resBuf <= '0;
		end else if (capture) begin
			resBuf <= result;	// copy at done
		end else if (rd) begin
			resBuf <= {resBuf[0], resBuf[WordsPerOp-1:1]};	// rotate one word
		end
	end

	// readout wraps after WordsPerOp reads
	assign out = resBuf[0];

endmodule

`default_nettype wire

/* modExpTop.sv */
`timescale 1ns/100ps
`default_nettype none

module modExpTop import modExpPkg::*; (
	input  logic  iClk,
	input  logic  M_reset0,
	input  logic  iStart,
	input  logic  iWrM,
	input  logic  iWrE,
	input  logic  iWrN,
	input  logic  iRdR,
	input  word_t iM,
	input  word_t iE,
	input  word_t iN,
	output word_t oR,
	output logic  oDone
);

	operandSet_t operands;	// loaded set
	addSubReq_t addSubReq;
	addSubRsp_t addSubRsp;
	operand_t result;

	operandLoad operandLoad_i (
		.iClk     (iClk),
		.M_reset0 (M_reset0),
		.wrM      (iWrM),
		.wrE      (iWrE),
		.wrN      (iWrN),
		.m        (iM),
		.e        (iE),
		.n        (iN),
		.operands (operands)
	);

	modExpCore modExpCore_i (
		.iClk      (iClk),
		.M_reset0  (M_reset0),
		.start     (iStart),
		.operands  (operands),
		.addSub    (addSubReq),
		.addSubRsp (addSubRsp),
		.result    (result),
		.done      (oDone)
	);

	serialAddSub serialAddSub_i (
		.iClk     (iClk),
		.M_reset0 (M_reset0),
		.req      (addSubReq),
		.rsp      (addSubRsp)
	);

	resultUnload resultUnload_i (
		.iClk     (iClk),
		.M_reset0 (M_reset0),
		.capture  (oDone),	// result word 0 on oR after done
		.result   (result),
		.rd       (iRdR),
		.out      (oR)
	);

endmodule

`default_nettype wire

/* modExp_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module modExp_chk import modExpPkg::*; (
	input logic       iClk,
	input logic       M_reset0,
	input logic       oDone,
	input addSubReq_t addSubReq,
	input addSubRsp_t addSubRsp
);

	donePulse: assert property (@(posedge iClk) disable iff (M_reset0)
		oDone |=> !oDone) else $error("oDone high two cycles in a row");	// one-cycle pulse

	noStartWhileShifting: assert property (@(posedge iClk) disable iff (M_reset0)
		!(addSubReq.start && addSubRsp.shift)) else $error("adder start during shifting");

	// first shift only right after a start
	shiftNeedsStart: assert property (@(posedge iClk) disable iff (M_reset0)
		(addSubRsp.shift && !$past(addSubRsp.shift)) |-> $past(addSubReq.start))
		else $error("adder shift with no active operation");

endmodule

bind modExpTop modExp_chk modExp_chk_i (
	.iClk      (iClk),
	.M_reset0  (M_reset0),
	.oDone     (oDone),
	.addSubReq (addSubReq),
	.addSubRsp (addSubRsp)
);

`default_nettype wire

/* tb_modExp.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_modExp import modExpPkg::*; ();

	localparam int ClkPeriod = 100;
	localparam int RunCycles = OpBits * 2 * OpBits * 15;	// exp bits x 2 mults x steps x cycles
	localparam int NumRuns = 16;	// 14 runs in all, plus margin
	localparam longint WatchdogNs = longint'(NumRuns) * RunCycles * ClkPeriod;

	logic iClk = 1'b0;
	logic M_reset0;
	logic iStart;
	logic iWrM;
	logic iWrE;
	logic iWrN;
	logic iRdR;
	word_t iM;
	word_t iE;
	word_t iN;
	word_t oR;
	logic oDone;
	logic [31:0] lcgState = 32'hc0c0;	// fixed seed
	int errCount = 0;
	int testCount = 0;
	int failCount = 0;

	modExpTop modExpTop_i (.*);

	always #(ClkPeriod / 2) iClk = ~iClk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic operand_t randOperand();
		operand_t v;
		for (int i = 0; i < OpBits / 32; i++) begin
			v[i*32 +: 32] = nextRand();
		end
		return v;
	endfunction

	// a * b mod n by add and double, one spare bit against overflow
	function automatic operand_t modMul(input operand_t a, input operand_t b, input operand_t n);
		logic [OpBits:0] acc;
		logic [OpBits:0] addend;
		logic [OpBits:0] wideN;
		acc = '0;
		addend = {1'b0, a};
		wideN = {1'b0, n};
		for (int i = 0; i < OpBits; i++) begin
			if (b[i]) begin
				acc = acc + addend;
				if (acc >= wideN) acc = acc - wideN;
			end
			addend = addend << 1;	// a * 2^(i+1) mod n
			if (addend >= wideN) addend = addend - wideN;
		end
		return acc[OpBits-1:0];
	endfunction

	task automatic modelModExp(input operand_t m, input operand_t e, input operand_t n,
			output operand_t r);
		operand_t b;
		r = operand_t'(1);
		b = m;
		for (int i = 0; i < OpBits; i++) begin
			if (e[i]) r = modMul(r, b, n);	// bit set, multiply in
			b = modMul(b, b, n);	// square for next bit
		end
	endtask

	task automatic makeOperands(output operand_t m, output operand_t e, output operand_t n);
		n = randOperand();
		n[OpBits-1] = 1'b0;	// keep n below 2^127
		if (n < 2) n = operand_t'(2);
		m = randOperand() % n;
		e = randOperand();
	endtask

	task automatic loadOperands(input operand_t m, input operand_t e, input operand_t n);
		for (int w = 0; w < WordsPerOp; w++) begin
			{iWrM, iWrE, iWrN} = 3'b111;
			iM = m[w*WordBits +: WordBits];	// low word first
			iE = e[w*WordBits +: WordBits];
			iN = n[w*WordBits +: WordBits];
			@(posedge iClk);
			#1;
		end
		{iWrM, iWrE, iWrN} = 3'b000;
	endtask

	task automatic startRun();
		iStart = 1'b1;
		@(posedge iClk);
		#1;
		iStart = 1'b0;
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (!oDone && cycles < RunCycles) begin
			@(posedge iClk);
			#1;
			cycles++;
		end
		if (!oDone) begin
			$display("no done pulse within %0d cycles after start", RunCycles);
			errCount++;
		end
		@(posedge iClk);	// buffer takes the result here
		#1;
	endtask

	task automatic readResult(output operand_t r);
		for (int w = 0; w < WordsPerOp; w++) begin
			r[w*WordBits +: WordBits] = oR;
			iRdR = 1'b1;	// a full turn leaves word 0 in front
			@(posedge iClk);
			#1;
		end
		iRdR = 1'b0;
	endtask

	task automatic runOnce(input operand_t m, input operand_t e, input operand_t n,
			output operand_t r);
		loadOperands(m, e, n);
		startRun();
		waitDone();
		readResult(r);
	endtask

	task automatic checkValue(input string name, input operand_t expected, input operand_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name, errCount - errBefore);
			failCount++;
		end
	endtask

	task automatic testReset();
		int errBefore;
		operand_t got;
		errBefore = errCount;
		for (int i = 0; i < 2 * SlicesPerOp; i++) begin
			if (oDone) begin
				$display("oDone went high with no start");
				errCount++;
			end
			@(posedge iClk);
			#1;
		end
		readResult(got);
		checkValue("reset", '0, got);	// buffer cleared by reset
		reportTest("reset", errBefore);
	endtask

	task automatic testZeroExp();
		int errBefore;
		operand_t m;
		operand_t e;
		operand_t n;
		operand_t got;
		errBefore = errCount;
		makeOperands(m, e, n);
		runOnce(m, '0, n, got);
		checkValue("zeroExp", operand_t'(1), got);	// M^0 is 1 for n > 1
		reportTest("zeroExp", errBefore);
	endtask

	task automatic testKnown();
		int errBefore;
		operand_t n;
		operand_t expected;
		operand_t got;
		errBefore = errCount;
		runOnce(operand_t'(4), operand_t'(13), operand_t'(497), got);
		checkValue("known 4^13 mod 497", operand_t'(445), got);
		n = {1'b0, {(OpBits-1){1'b1}}};	// 2^127 - 1
		modelModExp(operand_t'(2), operand_t'(100), n, expected);
		runOnce(operand_t'(2), operand_t'(100), n, got);
		checkValue("known 2^100 mod 2^127-1", expected, got);
		reportTest("known", errBefore);
	endtask

	task automatic testRandom();
		int errBefore;
		operand_t m;
		operand_t e;
		operand_t n;
		operand_t expected;
		operand_t got;
		errBefore = errCount;
		for (int i = 0; i < 8; i++) begin
			makeOperands(m, e, n);
			modelModExp(m, e, n, expected);
			runOnce(m, e, n, got);
			checkValue($sformatf("random %0d", i), expected, got);
		end
		reportTest("random", errBefore);
	endtask

	task automatic testLoadDuringRun();
		int errBefore;
		operand_t mA;
		operand_t eA;
		operand_t nA;
		operand_t mB;
		operand_t eB;
		operand_t nB;
		operand_t expected;
		operand_t got;
		errBefore = errCount;
		makeOperands(mA, eA, nA);
		makeOperands(mB, eB, nB);
		eA[OpBits-1] = 1'b1;	// long run, load ends well before done
		loadOperands(mA, eA, nA);
		startRun();
		loadOperands(mB, eB, nB);	// next set while the core works
		waitDone();
		readResult(got);
		modelModExp(mA, eA, nA, expected);
		checkValue("loadDuringRun first", expected, got);
		startRun();	// picks up set B
		waitDone();
		readResult(got);
		modelModExp(mB, eB, nB, expected);
		checkValue("loadDuringRun second", expected, got);
		reportTest("loadDuringRun", errBefore);
	endtask

	task automatic testReadOrder();
		int errBefore;
		int w;
		operand_t m;
		operand_t e;
		operand_t n;
		operand_t expected;
		operand_t got;
		errBefore = errCount;
		makeOperands(m, e, n);
		modelModExp(m, e, n, expected);
		runOnce(m, e, n, got);
		for (int k = 0; k <= WordsPerOp; k++) begin
			w = k % WordsPerOp;	// wraps back to word 0
			checkValue($sformatf("readOrder word %0d", w), expected[w*WordBits +: WordBits], oR);
			@(posedge iClk);	// idle cycle, no rotation
			#1;
			checkValue($sformatf("readOrder hold %0d", w), expected[w*WordBits +: WordBits], oR);
			iRdR = 1'b1;
			@(posedge iClk);
			#1;
			iRdR = 1'b0;
		end
		reportTest("readOrder", errBefore);
	endtask

	initial begin
		M_reset0 = 1'b1;
		iStart = 1'b0;
		{iWrM, iWrE, iWrN, iRdR} = 4'b0000;
		{iM, iE, iN} = '0;
		repeat (3) @(posedge iClk);
		#1;
		M_reset0 = 1'b0;
		testReset();
		testZeroExp();
		testKnown();
		testRandom();
		testLoadDuringRun();
		testReadOrder();
		$display("%0d tests run, %0d failed, %0d errors", testCount, failCount, errCount);
		if (errCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// bound from the worst case run length
	initial begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, run stopped", WatchdogNs);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
modExpPkg.sv
operandLoad.sv
serialAddSub.sv
modExpCore.sv
resultUnload.sv
modExpTop.sv
modExp_chk.sv
tb_modExp.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_modExp
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
